// File: design/id_branch_unit.sv
// combinational; JALR target has bit 0 cleared, misaligned targets are not flagged
`timescale 1ns/1ps
`default_nettype none

module id_branch_unit #(
  parameter int XLEN = 64
) (
  input  wire id_pkg::br_func_e i_br_func,
  input  wire  [XLEN-1:0]       i_pc,
  input  wire  [XLEN-1:0]       i_imm,
  input  wire  [XLEN-1:0]       i_rs1_data,
  input  wire  [XLEN-1:0]       i_rs2_data,
  output logic                  o_taken,
  output logic [XLEN-1:0]       o_target
);
  import id_pkg::*;

  logic            eq;
  logic            lt;
  logic            ltu;
  logic [XLEN-1:0] pc_sum;
  logic [XLEN-1:0] rs1_sum;

  assign eq  = (i_rs1_data == i_rs2_data);
  assign lt  = ($signed(i_rs1_data) < $signed(i_rs2_data));
  assign ltu = (i_rs1_data < i_rs2_data);

  always_comb begin
    case (i_br_func)
      BR_EQ:           o_taken = eq;
      BR_NE:           o_taken = !eq;
      BR_LT:           o_taken = lt;
      BR_GE:           o_taken = !lt;
      BR_LTU:          o_taken = ltu;
      BR_GEU:          o_taken = !ltu;
      BR_JAL, BR_JALR: o_taken = 1'b1;
      default:         o_taken = 1'b0;
    endcase
  end

  assign pc_sum  = i_pc + i_imm;
  assign rs1_sum = i_rs1_data + i_imm;

  assign o_target = (i_br_func == BR_JALR) ? {rs1_sum[XLEN-1:1], 1'b0} : pc_sum;

endmodule

`default_nettype wire

// File: design/id_decoder.sv
// RV32I/RV64I integer subset only; CSR, system, fence and word ops decode as invalid
`timescale 1ns/1ps
`default_nettype none

module id_decoder #(
  parameter int XLEN = 64
) (
  input  wire  [id_pkg::INST_W-1:0]     i_inst,
  output logic [id_pkg::REG_ADDR_W-1:0] o_rs1,
  output logic [id_pkg::REG_ADDR_W-1:0] o_rs2,
  output logic [id_pkg::REG_ADDR_W-1:0] o_rd,
  output logic [XLEN-1:0]               o_imm,
  output id_pkg::alu_op_e               o_alu_op,
  output id_pkg::br_func_e              o_br_func,
  output logic                          o_alu_src1_pc,
  output logic                          o_alu_src2_imm,
  output logic                          o_gpr_wen,
  output logic                          o_mem_ren,
  output logic                          o_mem_wen,
  output logic                          o_load_sel,
  output logic                          o_invalid
);
  import id_pkg::*;

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic            is_op;
  logic            shamt_ok;
  alu_op_e         arith_op;
  logic            arith_ok;
  logic            use_rs1;
  logic            use_rs2;

  assign opcode   = opcode_e'(i_inst[6:0]);
  assign funct3   = i_inst[14:12];
  assign funct7   = i_inst[31:25];
  assign is_op    = (opcode == OPC_OP);
  assign shamt_ok = (XLEN == 64) || !i_inst[25]; // 6-bit shamt only on RV64

  assign imm_i = {{(XLEN-11){i_inst[31]}}, i_inst[30:20]};
  assign imm_s = {{(XLEN-11){i_inst[31]}}, i_inst[30:25], i_inst[11:7]};
  assign imm_b = {{(XLEN-12){i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{(XLEN-31){i_inst[31]}}, i_inst[30:12], 12'b0};
  assign imm_j = {{(XLEN-20){i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  // OP and OP-IMM share funct3, funct7 only picks SUB/SRA
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (is_op && funct7[5]) ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = funct7[5] ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
    arith_ok = 1'b1;
    if (is_op) begin
      arith_ok = (funct7 == 7'b0) ||
                 (funct7 == 7'b010_0000 && (funct3 == 3'b000 || funct3 == 3'b101));
    end else if (funct3 == 3'b001) begin
      arith_ok = (i_inst[31:26] == 6'b0) && shamt_ok;
    end else if (funct3 == 3'b101) begin
      arith_ok = (i_inst[31:26] == 6'b0 || i_inst[31:26] == 6'b01_0000) && shamt_ok;
    end
  end

  always_comb begin
    o_imm          = '0;
    o_alu_op       = ALU_ADD;
    o_br_func      = BR_NONE;
    o_alu_src1_pc  = 1'b0;
    o_alu_src2_imm = 1'b0;
    o_gpr_wen      = 1'b0;
    o_mem_ren      = 1'b0;
    o_mem_wen      = 1'b0;
    o_load_sel     = 1'b0;
    o_invalid      = 1'b0;
    use_rs1        = 1'b0;
    use_rs2        = 1'b0;
    case (opcode)
      OPC_OP, OPC_OP_IMM: begin
        use_rs1        = 1'b1;
        use_rs2        = is_op;
        o_imm          = imm_i;
        o_alu_op       = arith_op;
        o_alu_src2_imm = !is_op;
        o_gpr_wen      = arith_ok;
        o_invalid      = !arith_ok;
      end
      OPC_LUI, OPC_AUIPC: begin
        o_imm          = imm_u;
        o_alu_src1_pc  = (opcode == OPC_AUIPC);
        o_alu_src2_imm = 1'b1;
        o_gpr_wen      = 1'b1;
      end
      OPC_LOAD: begin  // lb lh lw lbu lhu, plus ld lwu on RV64
        use_rs1        = 1'b1;
        o_imm          = imm_i;
        o_alu_src2_imm = 1'b1;
        o_invalid      = (funct3 == 3'b111) ||
                         (XLEN == 32 && (funct3 == 3'b011 || funct3 == 3'b110));
        o_gpr_wen      = !o_invalid;
        o_mem_ren      = !o_invalid;
        o_load_sel     = !o_invalid;
      end
      OPC_STORE: begin
        use_rs1        = 1'b1;
        use_rs2        = 1'b1;
        o_imm          = imm_s;
        o_alu_src2_imm = 1'b1;
        o_invalid      = funct3[2] || (XLEN == 32 && funct3 == 3'b011);
        o_mem_wen      = !o_invalid;
      end
      OPC_BRANCH: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        o_imm   = imm_b;
        case (funct3)
          3'b000:  o_br_func = BR_EQ;
          3'b001:  o_br_func = BR_NE;
          3'b100:  o_br_func = BR_LT;
          3'b101:  o_br_func = BR_GE;
          3'b110:  o_br_func = BR_LTU;
          3'b111:  o_br_func = BR_GEU;
          default: o_invalid = 1'b1;
        endcase
      end
      OPC_JAL: begin
        o_imm         = imm_j;
        o_br_func     = BR_JAL;
        o_alu_src1_pc = 1'b1;  // link = pc + 4
        o_gpr_wen     = 1'b1;
      end
      OPC_JALR: begin
        use_rs1       = 1'b1;
        o_imm         = imm_i;
        o_invalid     = (funct3 != 3'b000);
        o_br_func     = o_invalid ? BR_NONE : BR_JALR;
        o_alu_src1_pc = 1'b1;
        o_gpr_wen     = !o_invalid;
      end
      default: o_invalid = 1'b1;
    endcase
    if (i_inst[11:7] == '0) begin
      o_gpr_wen = 1'b0;  // x0 is never written
    end
  end

  assign o_rs1 = use_rs1 ? i_inst[19:15] : '0;
  assign o_rs2 = use_rs2 ? i_inst[24:20] : '0;
  assign o_rd  = o_gpr_wen ? i_inst[11:7] : '0;  // no destination for branch/store

  always_comb begin
    a_invalid_quiet: assert final (!o_invalid || !(o_gpr_wen || o_mem_ren || o_mem_wen))
      else $error("invalid instruction %h left an enable set", i_inst);
  end

endmodule

`default_nettype wire

// File: design/id_operand_fwd.sv
// combinational; expects the register file to return zero for x0
`timescale 1ns/1ps
`default_nettype none

module id_operand_fwd #(
  parameter int XLEN = 64
) (
  input  wire  [id_pkg::REG_ADDR_W-1:0] i_rs,
  input  wire  [XLEN-1:0]               i_rf_data,
  input  wire  [id_pkg::REG_ADDR_W-1:0] i_es_byp_rd,
  input  wire  [XLEN-1:0]               i_es_byp_result,
  input  wire                           i_es_load_sel,
  input  wire  [id_pkg::REG_ADDR_W-1:0] i_ms_byp_rd,
  input  wire  [XLEN-1:0]               i_ms_byp_result,
  input  wire                           i_ms_byp_stall,
  input  wire  [id_pkg::REG_ADDR_W-1:0] i_ws_byp_rd,
  input  wire  [XLEN-1:0]               i_ws_byp_result,
  output logic [XLEN-1:0]               o_data,
  output logic                          o_stall
);

  logic es_hit;
  logic ms_hit;
  logic ws_hit;

  // rd 0 means no write in that stage
  assign es_hit = (i_es_byp_rd != '0) && (i_es_byp_rd == i_rs);
  assign ms_hit = (i_ms_byp_rd != '0) && (i_ms_byp_rd == i_rs);
  assign ws_hit = (i_ws_byp_rd != '0) && (i_ws_byp_rd == i_rs);

  // youngest producer wins
  assign o_data = es_hit ? i_es_byp_result :
                  ms_hit ? i_ms_byp_result :
                  ws_hit ? i_ws_byp_result :
                           i_rf_data;

  // load data not back yet, or ms result not final
  assign o_stall = (es_hit && i_es_load_sel) || (ms_hit && i_ms_byp_stall);

  always_comb begin
    a_x0_reads_zero: assert final (i_rs != '0 || o_data == '0)
      else $error("x0 operand read as %h", o_data);
  end

endmodule

`default_nettype wire

// File: design/id_pkg.sv
// shared decode types; opcode values follow the RV32I/RV64I base encoding only
`default_nettype none

package id_pkg;

  localparam int INST_W     = 32;
  localparam int REG_ADDR_W = 5;

  localparam logic [INST_W-1:0] NOP_INST = 32'h0000_0013; // addi x0, x0, 0

  // major opcode field, inst[6:0]
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b000_0011,
    OPC_OP_IMM = 7'b001_0011,
    OPC_AUIPC  = 7'b001_0111,
    OPC_STORE  = 7'b010_0011,
    OPC_OP     = 7'b011_0011,
    OPC_LUI    = 7'b011_0111,
    OPC_BRANCH = 7'b110_0011,
    OPC_JALR   = 7'b110_0111,
    OPC_JAL    = 7'b110_1111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  // branch/jump function resolved in decode
  typedef enum logic [3:0] {
    BR_NONE = 4'd0,
    BR_EQ   = 4'd1,
    BR_NE   = 4'd2,
    BR_LT   = 4'd3,
    BR_GE   = 4'd4,
    BR_LTU  = 4'd5,
    BR_GEU  = 4'd6,
    BR_JAL  = 4'd7,  // always taken, pc relative
    BR_JALR = 4'd8   // always taken, rs1 relative
  } br_func_e;

endpackage

`default_nettype wire

// File: design/id_regfile.sv
// x0 hard-wired to zero; a write is readable from the next cycle, same cycle needs the ws bypass
`timescale 1ns/1ps
`default_nettype none

module id_regfile #(
  parameter int XLEN = 64
) (
  input  wire                           i_clk,
  input  wire                           i_reset,
  input  wire  [id_pkg::REG_ADDR_W-1:0] i_raddr1,
  input  wire  [id_pkg::REG_ADDR_W-1:0] i_raddr2,
  input  wire                           i_wen,
  input  wire  [id_pkg::REG_ADDR_W-1:0] i_waddr,
  input  wire  [XLEN-1:0]               i_wdata,
  output logic [XLEN-1:0]               o_rdata1,
  output logic [XLEN-1:0]               o_rdata2
);

  logic [XLEN-1:0] regs [31:1];  // no storage behind x0

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

`default_nettype wire

// File: design/id_stage.sv
// XLEN 32 or 64; load/store width is not passed on, link instructions carry 4 on rs2 data
`timescale 1ns/1ps
`default_nettype none

module id_stage #(
  parameter int XLEN = 64
) (
  input  wire                           i_clk,
  input  wire                           i_reset,
  // fetch side
  input  wire                           i_fs_to_ds_valid,
  input  wire  [id_pkg::INST_W-1:0]     i_fs_inst,
  input  wire  [XLEN-1:0]               i_fs_pc,
  output logic                          o_ds_allowin,
  output logic                          o_br_taken,
  output logic [XLEN-1:0]               o_br_target,
  // execute side
  input  wire                           i_es_allowin,
  output logic                          o_ds_to_es_valid,
  output logic [XLEN-1:0]               o_ds_pc,
  output logic [XLEN-1:0]               o_ds_rs1_data,
  output logic [XLEN-1:0]               o_ds_rs2_data,
  output logic [XLEN-1:0]               o_ds_imm,
  output logic [id_pkg::REG_ADDR_W-1:0] o_ds_rd,
  output id_pkg::alu_op_e               o_ds_alu_op,
  output logic                          o_ds_alu_src1_pc,
  output logic                          o_ds_alu_src2_imm,
  output logic                          o_ds_gpr_wen,
  output logic                          o_ds_mem_ren,
  output logic                          o_ds_mem_wen,
  output logic                          o_ds_load_sel,
  output logic                          o_ds_invalid,
  // write back
  input  wire                           i_ws_rf_wen,
  input  wire  [id_pkg::REG_ADDR_W-1:0] i_ws_rf_waddr,
  input  wire  [XLEN-1:0]               i_ws_rf_wdata,
  // bypass
  input  wire  [id_pkg::REG_ADDR_W-1:0] i_es_byp_rd,
  input  wire  [XLEN-1:0]               i_es_byp_result,
  input  wire                           i_es_load_sel,
  input  wire  [id_pkg::REG_ADDR_W-1:0] i_ms_byp_rd,
  input  wire  [XLEN-1:0]               i_ms_byp_result,
  input  wire                           i_ms_byp_stall,
  input  wire  [id_pkg::REG_ADDR_W-1:0] i_ws_byp_rd,
  input  wire  [XLEN-1:0]               i_ws_byp_result
);
  import id_pkg::*;

  logic                  ds_valid;
  logic                  ds_ready_go;
  logic                  accept;
  logic [INST_W-1:0]     ds_inst;
  logic [XLEN-1:0]       ds_pc;
  logic [REG_ADDR_W-1:0] src_rs      [2];  // 0 = rs1, 1 = rs2
  logic [XLEN-1:0]       src_rf_data [2];
  logic [XLEN-1:0]       src_data    [2];
  logic [1:0]            src_stall;
  br_func_e              br_func;
  logic                  br_resolved;
  logic                  is_link;

  assign ds_ready_go      = ~|src_stall;
  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;
  assign accept           = i_fs_to_ds_valid && o_ds_allowin;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ds_inst <= NOP_INST;
      ds_pc   <= '0;
    end else if (accept) begin
      ds_inst <= o_br_taken ? NOP_INST : i_fs_inst;  // wrong-path slot becomes a nop
      ds_pc   <= i_fs_pc;
    end
  end

  id_decoder #(.XLEN(XLEN)) u_decoder (
    .i_inst         (ds_inst),
    .o_rs1          (src_rs[0]),
    .o_rs2          (src_rs[1]),
    .o_rd           (o_ds_rd),
    .o_imm          (o_ds_imm),
    .o_alu_op       (o_ds_alu_op),
    .o_br_func      (br_func),
    .o_alu_src1_pc  (o_ds_alu_src1_pc),
    .o_alu_src2_imm (o_ds_alu_src2_imm),
    .o_gpr_wen      (o_ds_gpr_wen),
    .o_mem_ren      (o_ds_mem_ren),
    .o_mem_wen      (o_ds_mem_wen),
    .o_load_sel     (o_ds_load_sel),
    .o_invalid      (o_ds_invalid)
  );

  id_regfile #(.XLEN(XLEN)) u_regfile (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_raddr1 (src_rs[0]),
    .i_raddr2 (src_rs[1]),
    .i_wen    (i_ws_rf_wen),
    .i_waddr  (i_ws_rf_waddr),
    .i_wdata  (i_ws_rf_wdata),
    .o_rdata1 (src_rf_data[0]),
    .o_rdata2 (src_rf_data[1])
  );

  for (genvar g = 0; g < 2; g++) begin : g_fwd
    id_operand_fwd #(.XLEN(XLEN)) u_fwd (
      .i_rs            (src_rs[g]),
      .i_rf_data       (src_rf_data[g]),
      .i_es_byp_rd     (i_es_byp_rd),
      .i_es_byp_result (i_es_byp_result),
      .i_es_load_sel   (i_es_load_sel),
      .i_ms_byp_rd     (i_ms_byp_rd),
      .i_ms_byp_result (i_ms_byp_result),
      .i_ms_byp_stall  (i_ms_byp_stall),
      .i_ws_byp_rd     (i_ws_byp_rd),
      .i_ws_byp_result (i_ws_byp_result),
      .o_data          (src_data[g]),
      .o_stall         (src_stall[g])
    );
  end

  id_branch_unit #(.XLEN(XLEN)) u_branch (
    .i_br_func  (br_func),
    .i_pc       (ds_pc),
    .i_imm      (o_ds_imm),
    .i_rs1_data (src_data[0]),
    .i_rs2_data (src_data[1]),
    .o_taken    (br_resolved),
    .o_target   (o_br_target)
  );

  // redirect only once the branch can leave
  assign o_br_taken = o_ds_to_es_valid && br_resolved;

  assign is_link       = (br_func == BR_JAL) || (br_func == BR_JALR);
  assign o_ds_pc       = ds_pc;
  assign o_ds_rs1_data = src_data[0];
  assign o_ds_rs2_data = is_link ? XLEN'(4) : src_data[1];  // pc + 4 for the link

  a_redirect_on_leave: assert property (@(posedge i_clk) disable iff (i_reset)
    o_br_taken |-> o_ds_to_es_valid);

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# builds and runs the ID stage testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_id_stage -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output="$(./obj_dir/Vtb_id_stage)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Test completed successfully" <<< "$output"; then
  exit 0
fi
exit 1

// File: testbench/tb_id_stage.sv
// directed tests at XLEN 64; bypass and write-back inputs are driven directly, no pipeline model
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;
  import id_pkg::*;

  localparam int XLEN       = 64;
  localparam int MAX_CYCLES = 400;  // tests need about 70 cycles

  logic            clk = 1'b0;
  logic            rst;
  logic            fs_valid, es_allowin, ds_allowin, br_taken, ds_to_es_valid;
  logic [31:0]     fs_inst;
  logic [XLEN-1:0] fs_pc, br_target, ds_pc, rs1_data, rs2_data, ds_imm;
  logic [4:0]      ds_rd;
  logic [3:0]      ds_alu_op;
  logic            src1_pc, src2_imm, gpr_wen, mem_ren, mem_wen, load_sel, ds_invalid;
  logic            ws_rf_wen, es_load_sel, ms_byp_stall;
  logic [4:0]      ws_rf_waddr, es_byp_rd, ms_byp_rd, ws_byp_rd;
  logic [XLEN-1:0] ws_rf_wdata, es_byp_result, ms_byp_result, ws_byp_result;

  int              cycles = 0;
  int              checks = 0;
  int              errors = 0;
  int              errors_at_start;
  string           cur_test;
  logic [63:0]     r1, r2, r3, r4;

  id_stage #(.XLEN(XLEN)) u_dut (
    .i_clk (clk), .i_reset (rst),
    .i_fs_to_ds_valid (fs_valid), .i_fs_inst (fs_inst), .i_fs_pc (fs_pc),
    .o_ds_allowin (ds_allowin), .o_br_taken (br_taken), .o_br_target (br_target),
    .i_es_allowin (es_allowin), .o_ds_to_es_valid (ds_to_es_valid), .o_ds_pc (ds_pc),
    .o_ds_rs1_data (rs1_data), .o_ds_rs2_data (rs2_data), .o_ds_imm (ds_imm),
    .o_ds_rd (ds_rd), .o_ds_alu_op (ds_alu_op), .o_ds_alu_src1_pc (src1_pc),
    .o_ds_alu_src2_imm (src2_imm), .o_ds_gpr_wen (gpr_wen), .o_ds_mem_ren (mem_ren),
    .o_ds_mem_wen (mem_wen), .o_ds_load_sel (load_sel), .o_ds_invalid (ds_invalid),
    .i_ws_rf_wen (ws_rf_wen), .i_ws_rf_waddr (ws_rf_waddr), .i_ws_rf_wdata (ws_rf_wdata),
    .i_es_byp_rd (es_byp_rd), .i_es_byp_result (es_byp_result),
    .i_es_load_sel (es_load_sel), .i_ms_byp_rd (ms_byp_rd),
    .i_ms_byp_result (ms_byp_result), .i_ms_byp_stall (ms_byp_stall),
    .i_ws_byp_rd (ws_byp_rd), .i_ws_byp_result (ws_byp_result)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("Test failed");
      $finish;
    end
  end

  // RISC-V base encodings
  function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                        input int f3, input int rd);
    enc_r = {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                        input int rd, input int opc);
    enc_i = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1,
                                        input int f3);
    enc_s = {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1,
                                        input int f3);
    enc_b = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(input int imm, input int rd);
    enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  task automatic expect_eq(input string field, input logic [63:0] exp, input logic [63:0] got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %s %s: expected %h, actual %h", cur_test, field, exp, got);
    end
  endtask

  task automatic expect_flag(input string field, input logic exp, input logic got);
    expect_eq(field, {63'b0, exp}, {63'b0, got});
  endtask

  task automatic expect_ctrl(input logic gpr, input logic ren, input logic wen, input logic inv);
    expect_flag("gpr_wen", gpr, gpr_wen);
    expect_flag("mem_ren", ren, mem_ren);
    expect_flag("mem_wen", wen, mem_wen);
    expect_flag("invalid", inv, ds_invalid);
  endtask

  task automatic start_test(input string name);
    cur_test        = name;
    errors_at_start = errors;
  endtask

  task automatic finish_test();
    if (errors == errors_at_start) $display("[done] %s ok", cur_test);
    else $display("[done] %s with %0d mismatches", cur_test, errors - errors_at_start);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  // returns 2 ns after the edge that took the offered instruction
  task automatic wait_accept();
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      #5 taken = ds_allowin;
      next_cycle();
    end
  endtask

  task automatic send(input logic [31:0] inst, input logic [63:0] pc);
    next_cycle();
    fs_valid = 1'b1;
    fs_inst  = inst;
    fs_pc    = pc;
    wait_accept();
    fs_valid = 1'b0;
    #5;
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [63:0] data);
    next_cycle();
    ws_rf_wen   = 1'b1;
    ws_rf_waddr = addr;
    ws_rf_wdata = data;
    next_cycle();
    ws_rf_wen = 1'b0;
  endtask

  task automatic test_reset_state();
    start_test("reset_state");
    expect_flag("to_es_valid", 1'b0, ds_to_es_valid);
    expect_flag("br_taken", 1'b0, br_taken);
    expect_flag("allowin", 1'b1, ds_allowin);
    finish_test();
  endtask

  task automatic test_decode();
    start_test("decode_regread");
    r1 = {$urandom(), $urandom()};
    r2 = {$urandom(), $urandom()};
    r3 = {$urandom(), $urandom()};
    r4 = {$urandom(), $urandom()};
    write_reg(5'd1, r1);
    write_reg(5'd2, r2);
    write_reg(5'd3, r3);
    write_reg(5'd4, r4);
    send(enc_r(0, 2, 1, 0, 5), 64'h100);  // add x5, x1, x2
    expect_eq("rs1", r1, rs1_data);
    expect_eq("rs2", r2, rs2_data);
    expect_eq("rd", 64'd5, 64'(ds_rd));
    expect_eq("alu_op", 64'(ALU_ADD), 64'(ds_alu_op));
    expect_flag("src2_imm", 1'b0, src2_imm);
    expect_flag("to_es_valid", 1'b1, ds_to_es_valid);
    expect_ctrl(1'b1, 1'b0, 1'b0, 1'b0);
    send(enc_i(-5, 1, 0, 6, 'h13), 64'h104);  // addi x6, x1, -5
    expect_eq("rs1", r1, rs1_data);
    expect_eq("imm", 64'hFFFF_FFFF_FFFF_FFFB, ds_imm);
    expect_eq("rd", 64'd6, 64'(ds_rd));
    expect_flag("src2_imm", 1'b1, src2_imm);
    expect_ctrl(1'b1, 1'b0, 1'b0, 1'b0);
    send({20'h80000, 5'd7, 7'h37}, 64'h108);  // lui x7, 0x80000
    expect_eq("imm", 64'hFFFF_FFFF_8000_0000, ds_imm);
    expect_eq("rd", 64'd7, 64'(ds_rd));
    expect_flag("src1_pc", 1'b0, src1_pc);
    expect_ctrl(1'b1, 1'b0, 1'b0, 1'b0);
    send(enc_i(16, 3, 3, 8, 'h03), 64'h10c);  // ld x8, 16(x3)
    expect_eq("rs1", r3, rs1_data);
    expect_eq("imm", 64'd16, ds_imm);
    expect_eq("rd", 64'd8, 64'(ds_rd));
    expect_flag("load_sel", 1'b1, load_sel);
    expect_ctrl(1'b1, 1'b1, 1'b0, 1'b0);
    send(enc_s(-8, 2, 1, 3), 64'h110);  // sd x2, -8(x1)
    expect_eq("rs1", r1, rs1_data);
    expect_eq("rs2", r2, rs2_data);
    expect_eq("imm", 64'hFFFF_FFFF_FFFF_FFF8, ds_imm);
    expect_eq("rd", 64'd0, 64'(ds_rd));
    expect_ctrl(1'b0, 1'b0, 1'b1, 1'b0);
    send(32'hFFFF_FFFF, 64'h114);
    expect_eq("rd", 64'd0, 64'(ds_rd));
    expect_ctrl(1'b0, 1'b0, 1'b0, 1'b1);
    finish_test();
  endtask

  task automatic test_forwarding();
    logic [63:0] es_v, ms_v, ws_v;
    start_test("forward_priority");
    es_v = {$urandom(), $urandom()};
    ms_v = {$urandom(), $urandom()};
    ws_v = {$urandom(), $urandom()};
    next_cycle();  // previous instruction drains first
    es_allowin = 1'b0;  // hold the instruction while the bypass changes
    send(enc_r(0, 0, 4, 0, 11), 64'h800);  // add x11, x4, x0
    next_cycle();
    es_byp_rd     = 5'd4;
    es_byp_result = es_v;
    ms_byp_rd     = 5'd4;
    ms_byp_result = ms_v;
    ws_byp_rd     = 5'd4;
    ws_byp_result = ws_v;
    #5 expect_eq("rs1 from es", es_v, rs1_data);
    expect_eq("x0 operand", 64'd0, rs2_data);
    next_cycle();
    es_byp_rd = 5'd0;
    #5 expect_eq("rs1 from ms", ms_v, rs1_data);
    next_cycle();
    ms_byp_rd = 5'd0;
    #5 expect_eq("rs1 from ws", ws_v, rs1_data);
    next_cycle();
    ws_byp_rd = 5'd0;
    #5 expect_eq("rs1 from regfile", r4, rs1_data);
    expect_eq("x0 operand", 64'd0, rs2_data);
    next_cycle();
    es_allowin = 1'b1;
    next_cycle();
    finish_test();
  endtask

  task automatic test_stalls();
    logic [63:0] v;
    start_test("hazard_stall");
    v = {$urandom(), $urandom()};
    next_cycle();
    es_byp_rd     = 5'd12;
    es_byp_result = v;
    es_load_sel   = 1'b1;
    send(enc_r(0, 0, 12, 0, 13), 64'h700);  // add x13, x12, x0 behind a load
    expect_flag("to_es_valid", 1'b0, ds_to_es_valid);
    expect_flag("allowin", 1'b0, ds_allowin);
    next_cycle();
    #5 expect_flag("to_es_valid", 1'b0, ds_to_es_valid);
    next_cycle();
    es_load_sel = 1'b0;
    #5 expect_flag("to_es_valid", 1'b1, ds_to_es_valid);
    expect_flag("allowin", 1'b1, ds_allowin);
    expect_eq("rs1", v, rs1_data);
    next_cycle();
    es_byp_rd     = 5'd0;
    ms_byp_rd     = 5'd14;
    ms_byp_result = ~v;
    ms_byp_stall  = 1'b1;
    send(enc_r(0, 14, 0, 0, 15), 64'h704);  // add x15, x0, x14
    expect_flag("to_es_valid", 1'b0, ds_to_es_valid);
    expect_flag("allowin", 1'b0, ds_allowin);
    next_cycle();
    #5 expect_flag("to_es_valid", 1'b0, ds_to_es_valid);
    next_cycle();
    ms_byp_stall = 1'b0;
    #5 expect_flag("to_es_valid", 1'b1, ds_to_es_valid);
    expect_flag("allowin", 1'b1, ds_allowin);
    expect_eq("rs2", ~v, rs2_data);
    next_cycle();
    ms_byp_rd = 5'd0;
    finish_test();
  endtask

  task automatic test_backpressure();
    start_test("backpressure");
    es_allowin = 1'b0;
    send(enc_i(100, 1, 0, 16, 'h13), 64'h600);  // addi x16, x1, 100
    for (int i = 0; i < 3; i++) begin
      expect_flag("to_es_valid", 1'b1, ds_to_es_valid);
      expect_flag("allowin", 1'b0, ds_allowin);
      expect_eq("pc", 64'h600, ds_pc);
      expect_eq("rd", 64'd16, 64'(ds_rd));
      expect_eq("imm", 64'd100, ds_imm);
      expect_eq("rs1", r1, rs1_data);
      next_cycle();
      fs_valid = 1'b1;  // next instruction waits at the input
      fs_inst  = enc_i(1, 2, 0, 17, 'h13);
      fs_pc    = 64'h604;
      #5;
    end
    next_cycle();
    es_allowin = 1'b1;
    #5 expect_flag("allowin", 1'b1, ds_allowin);
    expect_eq("pc", 64'h600, ds_pc);
    next_cycle();
    fs_valid = 1'b0;
    #5 expect_eq("pc", 64'h604, ds_pc);
    expect_eq("rd", 64'd17, 64'(ds_rd));
    finish_test();
  endtask

  task automatic test_branches();
    start_test("branch_squash");
    write_reg(5'd20, 64'd5);
    write_reg(5'd21, 64'd5);
    write_reg(5'd22, 64'd7);
    write_reg(5'd23, 64'hFFFF_FFFF_FFFF_FFFF);
    write_reg(5'd24, 64'h1001);
    send(enc_b(16, 21, 20, 0), 64'h1000);  // beq equal
    expect_flag("beq taken", 1'b1, br_taken);
    expect_eq("beq target", 64'h1010, br_target);
    send(enc_b(16, 22, 20, 0), 64'h1100);  // beq not equal
    expect_flag("beq not taken", 1'b0, br_taken);
    send(enc_b(-32, 23, 22, 6), 64'h2000);  // bltu 7 < all ones
    expect_flag("bltu taken", 1'b1, br_taken);
    expect_eq("bltu target", 64'h1FE0, br_target);
    send(enc_j('h800, 1), 64'h3000);
    expect_flag("jal taken", 1'b1, br_taken);
    expect_eq("jal target", 64'h3800, br_target);
    send(enc_i(4, 24, 0, 5, 'h67), 64'h4000);  // jalr sum 0x1005
    expect_flag("jalr taken", 1'b1, br_taken);
    expect_eq("jalr target", 64'h1004, br_target);
    next_cycle();
    fs_valid = 1'b1;
    fs_inst  = enc_b(8, 21, 20, 0);
    fs_pc    = 64'h5000;
    wait_accept();
    fs_inst = enc_r(0, 2, 1, 0, 9);  // wrong-path add x9
    fs_pc   = 64'h5004;
    #5 expect_flag("squash beq taken", 1'b1, br_taken);
    expect_eq("squash beq target", 64'h5008, br_target);
    wait_accept();
    fs_valid = 1'b0;
    #5 expect_eq("nop pc", 64'h5004, ds_pc);
    expect_eq("nop rd", 64'd0, 64'(ds_rd));
    expect_flag("nop gpr_wen", 1'b0, gpr_wen);
    expect_flag("nop br_taken", 1'b0, br_taken);
    next_cycle();
    finish_test();
  endtask

  initial begin
    void'($urandom(97));
    rst           = 1'b1;
    fs_valid      = 1'b0;
    fs_inst       = 32'h0;
    fs_pc         = '0;
    es_allowin    = 1'b1;
    ws_rf_wen     = 1'b0;
    ws_rf_waddr   = 5'd0;
    ws_rf_wdata   = '0;
    es_byp_rd     = 5'd0;
    es_byp_result = '0;
    es_load_sel   = 1'b0;
    ms_byp_rd     = 5'd0;
    ms_byp_result = '0;
    ms_byp_stall  = 1'b0;
    ws_byp_rd     = 5'd0;
    ws_byp_result = '0;
    repeat (8) @(posedge clk);
    #2 rst = 1'b0;
    #5;
    test_reset_state();
    test_decode();
    test_forwarding();
    test_stalls();
    test_backpressure();
    test_branches();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
design/id_pkg.sv
design/id_decoder.sv
design/id_regfile.sv
design/id_operand_fwd.sv
design/id_branch_unit.sv
design/id_stage.sv
testbench/tb_id_stage.sv
